// File: hw/aes_enc_ctrl.sv
`timescale 1ns/1ns

module aes_enc_ctrl #(
    parameter int OUT_CREDIT_MAX = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  logic      out_credit,
    output logic      in_credit,
    output logic      out_valid,
    aes_round_if.ctrl rif
);
    import aes_pkg::*;

    localparam int CW = $clog2(OUT_CREDIT_MAX + 1);

    ctrl_state_e   state;
    ctrl_state_e   state_next;
    round_t        round_q;
    logic [CW-1:0] credit_cnt;
    logic [CW:0]   credit_sum;
    // producer holds the one input credit
    logic          credit_held;
    // a result may leave next cycle
    logic          out_ready;

    // a credit in flight this cycle counts as well
    assign out_ready = (credit_cnt != '0) || out_credit;

    // round strobes, at most one per cycle
    assign rif.load        = (state == LOAD) && in_valid;
    assign rif.mix_en      = (state == MIX);
    assign rif.key_add     = (state == KEY_ADD);
    assign rif.final_round = (state == FINAL);
    assign rif.round       = round_q;

    always_comb
    begin
        state_next = state;
        case (state)
            // hands out the first input credit
            IDLE:
                state_next = LOAD;
            LOAD:
                if (in_valid)
                begin
                    state_next = MIX;
                end
            MIX:
                state_next = KEY_ADD;
            KEY_ADD:
                if (round_q == round_t'(NUM_ROUNDS - 1))
                begin
                    state_next = FINAL;
                end
                else
                begin
                    state_next = MIX;
                end
            FINAL, HOLD:
                // wait here for an output credit
                state_next = out_ready ? LOAD : HOLD;
            default:
                state_next = IDLE;
        endcase
    end

    // add granted credit, take one back per result
    assign credit_sum = {1'b0, credit_cnt} + (CW + 1)'(out_credit) - (CW + 1)'(out_valid);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state       <= IDLE;
            round_q     <= '0;
            out_valid   <= 1'b0;
            in_credit   <= 1'b0;
            credit_cnt  <= '0;
            credit_held <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (rif.load)
            begin
                round_q <= round_t'(1);
            end
            else if (rif.key_add)
            begin
                round_q <= round_q + round_t'(1);
            end
            // result leaves the cycle after final or after the credit shows up
            out_valid <= ((state == FINAL) || (state == HOLD)) && out_ready;
            // slot is free again once the result has gone
            in_credit <= (state == IDLE) || out_valid;
            // saturate at the max
            if (credit_sum > OUT_CREDIT_MAX)
            begin
                credit_cnt <= CW'(OUT_CREDIT_MAX);
            end
            else
            begin
                credit_cnt <= credit_sum[CW-1:0];
            end
            credit_held <= (credit_held || in_credit) && !in_valid;
        end
    end

    // producer sends only on a credit it was given
    a_in_credit: assert property (@(posedge clk) disable iff (!reset)
        in_valid |-> credit_held);

    // every result is paid for
    a_out_credit: assert property (@(posedge clk) disable iff (!reset)
        out_valid |-> (credit_cnt != '0));

endmodule

// File: hw/aes_enc_top.sv
`timescale 1ns/1ns

module aes_enc_top #(
    parameter int OUT_CREDIT_MAX = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  aes_pkg::state_t in_block,
    input  aes_pkg::key_t   in_key,
    input  logic            out_credit,
    output logic            in_credit,
    output logic            out_valid,
    output aes_pkg::state_t out_block
);
    import aes_pkg::*;

    // current round key into the datapath
    key_t round_key;

    // round strobes shared by datapath and key schedule
    aes_round_if rif (
        .clk (clk)
    );

    // sequencer and credit accounting
    aes_enc_ctrl #(
        .OUT_CREDIT_MAX (OUT_CREDIT_MAX)
    ) aes_enc_ctrl_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .rif        (rif.ctrl)
    );

    // one key per round expanded on the fly
    aes_key_schedule aes_key_schedule_inst (
        .clk       (clk),
        .reset     (reset),
        .key_in    (in_key),
        .rif       (rif.datapath),
        .round_key (round_key)
    );

    // state register holds the ciphertext once the last round is done
    aes_round aes_round_inst (
        .clk       (clk),
        .reset     (reset),
        .round_key (round_key),
        .rif       (rif.datapath),
        .block_in  (in_block),
        .state     (out_block)
    );

endmodule

// File: hw/aes_key_schedule.sv
`timescale 1ns/1ns

module aes_key_schedule (
    input  logic          clk,
    input  logic          reset,
    input  aes_pkg::key_t key_in,
    aes_round_if.datapath rif,
    output aes_pkg::key_t round_key
);
    import aes_pkg::*;

    // key of the previous round, key 0 right after load
    key_t             key_q;
    key_t             next_key;
    logic [0:3][7:0]  temp;

    always_comb
    begin
        // rotword and subword on the last word of the key
        for (int b = 0; b < 4; b++)
        begin
            temp[b] = sbox[key_q[12 + ((b + 1) % 4)]];
        end
        temp[0] = temp[0] ^ rcon(rif.round);
        // word xor chain, each word takes the new word before it
        for (int i = 0; i < 16; i++)
        begin
            if (i < 4)
            begin
                next_key[i] = key_q[i] ^ temp[i];
            end
            else
            begin
                next_key[i] = key_q[i] ^ next_key[i - 4];
            end
        end
    end

    // cipher key goes straight through for the initial add
    assign round_key = rif.load ? key_in : next_key;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            key_q <= '0;
        end
        else if (rif.load)
        begin
            key_q <= key_in;
        end
        else if (rif.key_add || rif.final_round)
        begin
            // step once per round
            key_q <= next_key;
        end
    end

endmodule

// File: hw/aes_mix_columns.sv
`timescale 1ns/1ns

module aes_mix_columns (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  aes_pkg::state_t state,
    output aes_pkg::state_t state_out,
    output logic            done
);
    import aes_pkg::*;

    state_t mix_comb;

    // one matrix product per column
    // bytes 4c..4c+3 are rows 0..3 of column c
    genvar c;
    generate
        for (c = 0; c < 4; c++)
        begin : g_col
            assign mix_comb[4 * c]     = gf_mul2(state[4 * c]) ^ gf_mul3(state[4 * c + 1])
                                       ^ state[4 * c + 2] ^ state[4 * c + 3];
            assign mix_comb[4 * c + 1] = state[4 * c] ^ gf_mul2(state[4 * c + 1])
                                       ^ gf_mul3(state[4 * c + 2]) ^ state[4 * c + 3];
            assign mix_comb[4 * c + 2] = state[4 * c] ^ state[4 * c + 1]
                                       ^ gf_mul2(state[4 * c + 2]) ^ gf_mul3(state[4 * c + 3]);
            assign mix_comb[4 * c + 3] = gf_mul3(state[4 * c]) ^ state[4 * c + 1]
                                       ^ state[4 * c + 2] ^ gf_mul2(state[4 * c + 3]);
        end
    endgenerate

    // result register, loaded only when enabled
    always_ff @(posedge clk)
    begin
        if (enable)
        begin
            state_out <= mix_comb;
        end
    end

    // done follows enable by one cycle
    // low under reset, no false completion
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            done <= 1'b0;
        end
        else
        begin
            done <= enable;
        end
    end

    // done only ever answers a request from the round before
    a_done_after_enable: assert property (@(posedge clk) disable iff (!reset)
        done |-> $past(enable));

endmodule

// File: hw/aes_pkg.sv
package aes_pkg;

    // byte 4c+r is row r of column c
    // byte 0 sits in the top bits, so fips-197 hex strings map directly
    typedef logic [0:15][7:0] state_t;
    typedef logic [0:15][7:0] key_t;

    // round number, 0 is the initial key add
    typedef logic [3:0] round_t;

    localparam int NUM_ROUNDS = 10;

    // round sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        MIX,
        KEY_ADD,
        FINAL,
        HOLD
    } ctrl_state_e;

    // forward s-box
    localparam logic [7:0] sbox [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // xtime, reduce by 0x11b when the top bit falls out
    function automatic logic [7:0] gf_mul2(input logic [7:0] x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    endfunction

    // 3x = 2x ^ x
    function automatic logic [7:0] gf_mul3(input logic [7:0] x);
        return gf_mul2(x) ^ x;
    endfunction

    // round constant, first byte of the rcon word
    function automatic logic [7:0] rcon(input round_t r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

endpackage

// File: hw/aes_round.sv
`timescale 1ns/1ns

module aes_round (
    input  logic              clk,
    input  logic              reset,
    input  aes_pkg::key_t     round_key,
    aes_round_if.datapath     rif,
    input  aes_pkg::state_t   block_in,
    output aes_pkg::state_t   state
);
    import aes_pkg::*;

    state_t sub_bytes;
    state_t shift_rows;
    state_t mix_out;

    // subbytes then shiftrows, both straight from the state register
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            sub_bytes[i] = sbox[state[i]];
        end
        // row r rotates left by r columns
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shift_rows[4 * c + r] = sub_bytes[4 * ((c + r) % 4) + r];
            end
        end
    end

    aes_mix_columns aes_mix_columns_inst (
        .clk       (clk),
        .reset     (reset),
        .enable    (rif.mix_en),
        .state     (shift_rows),
        .state_out (mix_out),
        .done      (rif.mix_done)
    );

    // round state register
    always_ff @(posedge clk)
    begin
        if (rif.load)
        begin
            // initial addroundkey
            state <= block_in ^ round_key;
        end
        else if (rif.key_add)
        begin
            state <= mix_out ^ round_key;
        end
        else if (rif.final_round)
        begin
            // last round skips mixcolumns
            state <= shift_rows ^ round_key;
        end
    end

    // key add must consume a mix result made the cycle before
    a_key_add_mixed: assert property (@(posedge clk) disable iff (!reset)
        rif.key_add |-> rif.mix_done);

endmodule

// File: hw/aes_round_if.sv
`timescale 1ns/1ns

interface aes_round_if (
    input logic clk
);
    import aes_pkg::*;

    // round strobes from the sequencer
    logic   load;
    logic   mix_en;
    logic   key_add;
    logic   final_round;
    round_t round;
    // mix register holds a fresh result
    logic   mix_done;

    modport ctrl (
        input  clk,
        input  mix_done,
        output load,
        output mix_en,
        output key_add,
        output final_round,
        output round
    );

    modport datapath (
        input  clk,
        input  load,
        input  mix_en,
        input  key_add,
        input  final_round,
        input  round,
        output mix_done
    );

    // at most one round step per cycle, seen by datapath and key schedule alike
    a_one_step: assert property (@(posedge clk)
        $onehot0({load, mix_en, key_add, final_round}));

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, then run it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module aes_enc_tb -o aes_enc_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/aes_enc_sim)"
echo "$sim_out"
# the bench prints its pass line only when every check held
echo "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1

// File: sim.f
+incdir+tb
hw/aes_pkg.sv
hw/aes_round_if.sv
hw/aes_mix_columns.sv
hw/aes_round.sv
hw/aes_key_schedule.sv
hw/aes_enc_ctrl.sv
hw/aes_enc_top.sv
tb/aes_enc_tb.sv

// File: tb/aes_ref_model.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// lcg state, advanced once per draw
logic [31:0] lcg_state = 32'h2aa664d9;

// product in gf(2^8), shift and add, reduced by 0x11b
function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] aa;
    p = 8'h00;
    aa = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
        begin
            p = p ^ aa;
        end
        aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// s-box from the field inverse x^254 and the affine map
function automatic logic [7:0] sub_byte(input logic [7:0] x);
    logic [7:0] inv;
    inv = 8'h01;
    // 254 is 8'b11111110, square and multiply from the top bit
    for (int i = 7; i >= 0; i--)
    begin
        inv = gmul(inv, inv);
        if (i != 0)
        begin
            inv = gmul(inv, x);
        end
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// textbook aes-128, byte 4c+r is row r of column c, byte 0 in the top bits
function automatic logic [127:0] encrypt_block(input logic [127:0] pt, input logic [127:0] key);
    logic [31:0]  w [44];
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [31:0]  tmp;
    logic [7:0]   rc;
    logic [127:0] ct;
    // full key expansion up front
    for (int i = 0; i < 4; i++)
    begin
        w[i] = key[127 - 32 * i -: 32];
    end
    rc = 8'h01;
    for (int i = 4; i < 44; i++)
    begin
        tmp = w[i - 1];
        if (i % 4 == 0)
        begin
            // rotword, subword, rcon
            tmp = {sub_byte(tmp[23:16]) ^ rc, sub_byte(tmp[15:8]), sub_byte(tmp[7:0]),
                sub_byte(tmp[31:24])};
            rc = gmul(rc, 8'h02);
        end
        w[i] = w[i - 4] ^ tmp;
    end
    for (int b = 0; b < 16; b++)
    begin
        s[b] = pt[127 - 8 * b -: 8] ^ w[b / 4][31 - 8 * (b % 4) -: 8];
    end
    for (int r = 1; r <= 10; r++)
    begin
        // subbytes with shiftrows, row n moves left by n
        for (int c = 0; c < 4; c++)
        begin
            for (int n = 0; n < 4; n++)
            begin
                t[4 * c + n] = sub_byte(s[4 * ((c + n) % 4) + n]);
            end
        end
        for (int c = 0; c < 4; c++)
        begin
            if (r < 10)
            begin
                s[4 * c]     = gmul(t[4 * c], 2) ^ gmul(t[4 * c + 1], 3) ^ t[4 * c + 2]
                    ^ t[4 * c + 3];
                s[4 * c + 1] = t[4 * c] ^ gmul(t[4 * c + 1], 2) ^ gmul(t[4 * c + 2], 3)
                    ^ t[4 * c + 3];
                s[4 * c + 2] = t[4 * c] ^ t[4 * c + 1] ^ gmul(t[4 * c + 2], 2)
                    ^ gmul(t[4 * c + 3], 3);
                s[4 * c + 3] = gmul(t[4 * c], 3) ^ t[4 * c + 1] ^ t[4 * c + 2]
                    ^ gmul(t[4 * c + 3], 2);
            end
            else
            begin
                // no mixcolumns in the last round
                for (int n = 0; n < 4; n++)
                begin
                    s[4 * c + n] = t[4 * c + n];
                end
            end
        end
        for (int b = 0; b < 16; b++)
        begin
            s[b] = s[b] ^ w[4 * r + b / 4][31 - 8 * (b % 4) -: 8];
        end
    end
    for (int b = 0; b < 16; b++)
    begin
        ct[127 - 8 * b -: 8] = s[b];
    end
    return ct;
endfunction

// lcg step
function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// four draws make one block
function automatic logic [127:0] random_block();
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < 4; i++)
    begin
        v = {v[95:0], next_random()};
    end
    return v;
endfunction

`endif

// File: tb/aes_enc_tb.sv
`timescale 1ns/1ns

module aes_enc_tb;

    logic         clk;
    logic         reset;
    logic         in_valid;
    logic [127:0] in_block;
    logic [127:0] in_key;
    logic         out_credit;
    logic         in_credit;
    logic         out_valid;
    logic [127:0] out_block;

    // expected ciphertexts, oldest first
    logic [127:0] exp_q [$];
    int           errors = 0;
    int           results = 0;
    int           cycle = 0;
    // in_credit pulses seen, and credits the producer has spent
    int           in_credit_pulses = 0;
    int           credits_spent = 0;
    // output credits granted and not yet used by the core
    int           out_credits_open = 0;
    // cycle of the last in_valid, and whether its latency is fixed
    int           sent_cycle = 0;
    bit           latency_due = 1'b0;
    bit           timed_out = 1'b0;

    `include "aes_ref_model.svh"

    aes_enc_top #(
        .OUT_CREDIT_MAX (4)
    ) aes_enc_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_block   (in_block),
        .in_key     (in_key),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_block  (out_block)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] expected);
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // one result leaves, compare against the oldest expected block
    task automatic check_result();
        logic [127:0] expected;
        if (exp_q.size() == 0)
        begin
            report_problem("out_valid with no block in flight");
        end
        else
        begin
            expected = exp_q.pop_front();
            assert (out_block == expected)
            else report_mismatch("out_block", out_block, expected);
            if (latency_due)
            begin
                assert (cycle - sent_cycle == 20)
                else report_mismatch("out_valid latency", 128'(cycle - sent_cycle), 128'd20);
            end
        end
    endtask

    // monitor, samples right at the edge
    always @(posedge clk)
    begin
        if (reset)
        begin
            cycle            <= cycle + 1;
            in_credit_pulses <= in_credit_pulses + int'(in_credit);
            out_credits_open <= out_credits_open + int'(out_credit) - int'(out_valid);
            if (out_valid)
            begin
                results <= results + 1;
                check_result();
            end
        end
    end

    // every result is paid for by a granted credit
    a_out_paid: assert property (@(posedge clk) disable iff (!reset)
        out_valid |-> (out_credits_open > 0))
        else report_problem("out_valid while no output credit was granted");

    // slot comes back right after each result
    a_credit_back: assert property (@(posedge clk) disable iff (!reset)
        out_valid |=> in_credit)
        else report_problem("no in_credit in the cycle after out_valid");

    // only the first credit comes without a result before it
    a_credit_source: assert property (@(posedge clk) disable iff (!reset)
        in_credit |-> ($past(out_valid) || (in_credit_pulses == 0)))
        else report_problem("in_credit pulse with no result before it");

    a_one_credit: assert property (@(posedge clk) disable iff (!reset)
        (in_credit_pulses - credits_spent) <= 1)
        else report_problem("producer holds more than one input credit");

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // wait until the producer holds an input credit
    task automatic wait_in_credit();
        int n;
        n = 0;
        while (!timed_out && (in_credit_pulses - credits_spent) == 0)
        begin
            if (n == 100)
            begin
                report_problem("timeout waiting for in_credit");
                timed_out = 1'b1;
            end
            else
            begin
                tick();
                n++;
            end
        end
    endtask

    // wait until every sent block has come out
    task automatic wait_drained();
        int n;
        n = 0;
        while (!timed_out && exp_q.size() != 0)
        begin
            if (n == 100)
            begin
                report_problem("timeout waiting for out_valid");
                timed_out = 1'b1;
            end
            else
            begin
                tick();
                n++;
            end
        end
    endtask

    task automatic send_block(input logic [127:0] pt, input logic [127:0] key,
                              input logic [127:0] expected, input bit with_credit);
        wait_in_credit();
        if (!timed_out)
        begin
            exp_q.push_back(expected);
            latency_due = with_credit;
            sent_cycle = cycle;
            credits_spent++;
            in_valid = 1'b1;
            in_block = pt;
            in_key = key;
            tick();
            in_valid = 1'b0;
        end
    endtask

    task automatic grant_credit();
        out_credit = 1'b1;
        tick();
        out_credit = 1'b0;
    endtask

    initial
    begin
        logic [127:0] pt;
        logic [127:0] key;
        int           gap;
        clk = 1'b0;
        reset = 1'b0;
        in_valid = 1'b0;
        in_block = '0;
        in_key = '0;
        out_credit = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;

        // first credit arrives alone, nothing comes out
        wait_in_credit();
        repeat (3) tick();
        assert (in_credit_pulses == 1)
        else report_mismatch("in_credit pulses", 128'(in_credit_pulses), 128'd1);
        assert (results == 0)
        else report_problem("out_valid before any block was sent");

        // fips-197 appendix c.1
        pt = 128'h00112233445566778899aabbccddeeff;
        key = 128'h000102030405060708090a0b0c0d0e0f;
        assert (encrypt_block(pt, key) == 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
        else report_mismatch("reference model", encrypt_block(pt, key),
            128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        grant_credit();
        send_block(pt, key, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1);
        wait_drained();

        // random blocks, credit granted ahead so latency is fixed
        for (int k = 0; k < 20; k++)
        begin
            pt = random_block();
            key = random_block();
            grant_credit();
            send_block(pt, key, encrypt_block(pt, key), 1'b1);
            wait_drained();
        end

        // back-pressure, core waits in hold until a credit shows up
        for (int k = 0; k < 4 && !timed_out; k++)
        begin
            pt = random_block();
            key = random_block();
            send_block(pt, key, encrypt_block(pt, key), 1'b0);
            gap = 22 + int'(next_random() % 32'd30);
            repeat (gap)
            begin
                assert (!out_valid)
                else report_problem("out_valid while output credit was withheld");
                tick();
            end
            grant_credit();
            assert (out_valid)
            else report_problem("out_valid did not follow the out_credit pulse");
            wait_drained();
        end

        // one credit back per result, plus the first one
        repeat (3) tick();
        assert (results == 25)
        else report_mismatch("result count", 128'(results), 128'd25);
        assert (in_credit_pulses == results + 1)
        else report_mismatch("in_credit pulses", 128'(in_credit_pulses), 128'(results + 1));

        $display("results %0d, errors %0d", results, errors);
        if (errors == 0 && !timed_out)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
